/* ps2_kbd.f */
+incdir+rtl
rtl/ps2_kbd_pkg.sv
rtl/ps2_frame_rx.sv
rtl/scan_code_decoder.sv
rtl/key_event_fifo.sv
rtl/kbd_apb_regs.sv
rtl/ps2_kbd_top.sv
test/ps2_clk_gen.sv
test/ps2_kbd_checker.sv
test/ps2_kbd_tb.sv

/* rtl/kbd_apb_regs.sv */
/* apb3 slave, zero wait states, 32-bit data
   status: count[3:0], parity 8, overflow 9; event read pops; ctrl w1c bits 8 and 9 */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module kbd_apb_regs (
  input  logic                    clk,
  input  logic                    resetN,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`PS2_APB_AW-1:0]  paddr,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  ps2_kbd_pkg::key_event_t head,
  input  ps2_kbd_pkg::fifo_cnt_t  count,
  input  logic                    parity_err,
  input  logic                    overflow,
  output logic                    pop
);
  import ps2_kbd_pkg::*;

  localparam logic [`PS2_APB_AW-1:0] OFF_STATUS = `PS2_REG_STATUS;
  localparam logic [`PS2_APB_AW-1:0] OFF_EVENT  = `PS2_REG_EVENT;
  localparam logic [`PS2_APB_AW-1:0] OFF_CTRL   = `PS2_REG_CTRL;

  logic access;
  logic hit_status;
  logic hit_event;
  logic hit_ctrl;
  logic wr_ctrl;
  logic par_sticky;
  logic ovf_sticky;

  assign access     = psel && penable;
  assign hit_status = (paddr == OFF_STATUS);
  assign hit_event  = (paddr == OFF_EVENT);
  assign hit_ctrl   = (paddr == OFF_CTRL);
  assign wr_ctrl    = access && pwrite && hit_ctrl;

  assign pready  = 1'b1;
  assign pslverr = access && !(hit_status || hit_event || hit_ctrl);
  assign pop     = access && !pwrite && hit_event && (count != '0);

  // read mux, only driven in the access phase
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (hit_status) begin
        prdata[$bits(fifo_cnt_t)-1:0] = count;
        prdata[8]                     = par_sticky;
        prdata[9]                     = ovf_sticky;
      end else if (hit_event && count != '0) begin
        prdata[$bits(key_event_t)-1:0] = head;
      end
    end
  end

  // sticky errors, a new pulse wins over a clear
  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      par_sticky <= 1'b0;
      ovf_sticky <= 1'b0;
    end else begin
      if (parity_err)
        par_sticky <= 1'b1;
      else if (wr_ctrl && pwdata[8])
        par_sticky <= 1'b0;
      if (overflow)
        ovf_sticky <= 1'b1;
      else if (wr_ctrl && pwdata[9])
        ovf_sticky <= 1'b0;
    end
  end

  // popped entry must be a real event from the fifo
  a_pop_nonempty: assert property (@(posedge clk) disable iff (!resetN)
    pop |-> (count != '0) && head.valid);

endmodule

/* rtl/key_event_fifo.sv */
/* key event buffer, drops new events when full
   head reads back zero while empty */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module key_event_fifo (
  input  logic                    clk,
  input  logic                    resetN,
  input  ps2_kbd_pkg::key_event_t key_evt,
  input  logic                    pop,
  output ps2_kbd_pkg::key_event_t head,
  output ps2_kbd_pkg::fifo_cnt_t  count,
  output logic                    overflow
);
  import ps2_kbd_pkg::*;

  localparam int DEPTH = `PS2_FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);

  key_event_t    mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;    // both wrap naturally, depth is 2^PW
  logic          full;
  logic          empty;
  logic          do_push;
  logic          do_pop;

  assign full    = (count == fifo_cnt_t'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = key_evt.valid && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= key_evt.valid && full;  // event lost
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= key_evt;
  end

  assign head = empty ? '0 : mem[rd_ptr];

  a_count_bound: assert property (@(posedge clk) disable iff (!resetN)
    count <= fifo_cnt_t'(DEPTH));

endmodule

/* rtl/ps2_frame_rx.sv */
/* ps2 device-to-host frame receiver, odd parity, lsb first
   ps2_clk must stay well below the system clock; rx_byte.data holds until the next frame ends */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module ps2_frame_rx (
  input  logic                   clk,
  input  logic                   resetN,
  input  logic                   ps2_clk,
  input  logic                   ps2_data,
  output ps2_kbd_pkg::ps2_byte_t rx_byte,
  output logic                   parity_err
);
  import ps2_kbd_pkg::*;

  localparam int TO_W = $clog2(`PS2_FRAME_TIMEOUT + 1);

  rx_state_e       state;
  logic [2:0]      clk_sync;   // [0] first flop, [2] previous level for edge detect
  logic [1:0]      data_sync;
  logic            fall_q;     // registered falling edge of ps2_clk
  logic            bit_q;      // data level aligned with fall_q
  logic [7:0]      shift_q;
  logic [2:0]      bit_cnt;
  logic            par_q;
  logic [TO_W-1:0] idle_cnt;   // cycles since last ps2 clock edge
  logic            byte_valid;
  logic [7:0]      byte_data;

  // synchronizers, idle bus is high
  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      clk_sync  <= 3'b111;
      data_sync <= 2'b11;
      fall_q    <= 1'b0;
      bit_q     <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[1:0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      fall_q    <= clk_sync[2] & ~clk_sync[1];
      bit_q     <= data_sync[1];
    end
  end

  // frame fsm, one step per falling edge
  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN) begin
      state      <= rx_idle;
      bit_cnt    <= '0;
      idle_cnt   <= '0;
      byte_valid <= 1'b0;
      parity_err <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      parity_err <= 1'b0;
      if (state == rx_idle || fall_q)
        idle_cnt <= '0;
      else
        idle_cnt <= idle_cnt + 1'b1;

      if (fall_q) begin
        case (state)
          rx_idle: begin
            if (!bit_q) begin       // start bit
              state   <= rx_data;
              bit_cnt <= '0;
            end
          end
          rx_data: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= rx_parity;
          end
          rx_parity: state <= rx_stop;
          rx_stop: begin
            // odd parity over data and parity bit, stop must be high
            if (bit_q && (^{par_q, shift_q}))
              byte_valid <= 1'b1;
            else
              parity_err <= 1'b1;
            state <= rx_idle;
          end
          default: state <= rx_idle;
        endcase
      end else if (state != rx_idle && idle_cnt == TO_W'(`PS2_FRAME_TIMEOUT)) begin
        state <= rx_idle;           // stalled frame, give up
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fall_q && state == rx_data)
      shift_q <= {bit_q, shift_q[7:1]};  // lsb arrives first
    if (fall_q && state == rx_parity)
      par_q <= bit_q;
    if (fall_q && state == rx_stop)
      byte_data <= shift_q;
  end

  assign rx_byte.valid = byte_valid;
  assign rx_byte.data  = byte_data;

  a_no_valid_and_err: assert property (@(posedge clk) disable iff (!resetN)
    !(rx_byte.valid && parity_err));

endmodule

/* rtl/ps2_kbd_config.svh */
/* build-time limits of the ps2 keyboard receiver
   fifo depth must be a power of two, register offsets are byte offsets on a 32-bit bus */
`ifndef PS2_KBD_CONFIG_SVH
`define PS2_KBD_CONFIG_SVH

`define PS2_FIFO_DEPTH     8     // buffered key events
`define PS2_FRAME_TIMEOUT  2000  // system cycles without a ps2 clock edge before a frame is dropped
`define PS2_APB_AW         4     // apb address bits decoded

`define PS2_REG_STATUS     'h0   // count, sticky errors
`define PS2_REG_EVENT      'h4   // head event, read pops
`define PS2_REG_CTRL       'h8   // write 1 to clear sticky bits

`endif

/* rtl/ps2_kbd_pkg.sv */
/* types passed between the receiver stages
   count width follows the fifo depth of the config header */
`include "ps2_kbd_config.svh"

package ps2_kbd_pkg;

  // one received byte, valid is a single-cycle pulse
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } ps2_byte_t;

  // decoded key event, code[8] marks an E0 key
  typedef struct packed {
    logic       valid;
    logic       brk;   // 1 = key released
    logic [8:0] code;
  } key_event_t;

  // fifo fill level, one bit more than the pointers
  typedef logic [$clog2(`PS2_FIFO_DEPTH):0] fifo_cnt_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_e;

  typedef enum logic [3:0] {
    dec_idle,
    dec_sample_nor,      // latch a plain make code
    dec_new_make,        // announce make
    dec_wait_rel,        // seen F0
    dec_sample_rel,
    dec_new_break,       // announce break
    dec_wait_ext,        // seen E0
    dec_sample_ext,
    dec_wait_ext_rel,    // seen E0 F0
    dec_sample_ext_rel
  } dec_state_e;

  typedef enum logic [1:0] {
    cls_normal,          // 01..83
    cls_extended,        // E0
    cls_release,         // F0
    cls_other
  } byte_class_e;

endpackage

/* rtl/ps2_kbd_top.sv */
/* ps2 keyboard to apb, receive only
   poll status count before reading events, latency depends on ps2 clock phase */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module ps2_kbd_top (
  input  logic                   clk,
  input  logic                   resetN,
  input  logic                   ps2_clk,
  input  logic                   ps2_data,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`PS2_APB_AW-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr
);
  import ps2_kbd_pkg::*;

  ps2_byte_t  rx_byte;    // receiver -> decoder
  logic       parity_err;
  key_event_t key_evt;    // decoder -> fifo
  key_event_t head;       // fifo -> registers
  fifo_cnt_t  count;
  logic       overflow;
  logic       pop;

  ps2_frame_rx ps2_frame_rx_i (
    .clk        (clk),
    .resetN     (resetN),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .rx_byte    (rx_byte),
    .parity_err (parity_err)
  );

  scan_code_decoder scan_code_decoder_i (
    .clk     (clk),
    .resetN  (resetN),
    .rx_byte (rx_byte),
    .key_evt (key_evt)
  );

  key_event_fifo key_event_fifo_i (
    .clk      (clk),
    .resetN   (resetN),
    .key_evt  (key_evt),
    .pop      (pop),
    .head     (head),
    .count    (count),
    .overflow (overflow)
  );

  kbd_apb_regs kbd_apb_regs_i (
    .clk        (clk),
    .resetN     (resetN),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .head       (head),
    .count      (count),
    .parity_err (parity_err),
    .overflow   (overflow),
    .pop        (pop)
  );

endmodule

/* rtl/scan_code_decoder.sv */
/* scan code set 2 sequence decoder, make / F0 / E0 / E0 F0 only
   relies on rx_byte.data holding for one cycle after its valid pulse */
`timescale 1ns/1ps

module scan_code_decoder (
  input  logic                    clk,
  input  logic                    resetN,
  input  ps2_kbd_pkg::ps2_byte_t  rx_byte,
  output ps2_kbd_pkg::key_event_t key_evt
);
  import ps2_kbd_pkg::*;

  dec_state_e  state;
  dec_state_e  next_state;
  byte_class_e cls;
  logic        load;      // sample the code this cycle
  logic        ext_bit;   // msb of the sampled code
  logic [8:0]  code_q;

  // byte classifier
  always_comb begin
    if (rx_byte.data inside {[8'h01:8'h83]})
      cls = cls_normal;
    else if (rx_byte.data == 8'he0)
      cls = cls_extended;
    else if (rx_byte.data == 8'hf0)
      cls = cls_release;
    else
      cls = cls_other;   // E1, AA, FA ... ignored
  end

  always_ff @(posedge clk or negedge resetN) begin
    if (!resetN)
      state <= dec_idle;
    else
      state <= next_state;
  end

  always_ff @(posedge clk) begin
    if (load)
      code_q <= {ext_bit, rx_byte.data};
  end

  // moore next state
  always_comb begin
    next_state = state;
    load       = 1'b0;
    ext_bit    = 1'b0;
    case (state)
      dec_idle: begin
        if (rx_byte.valid) begin
          case (cls)
            cls_normal:   next_state = dec_sample_nor;
            cls_release:  next_state = dec_wait_rel;
            cls_extended: next_state = dec_wait_ext;
            default:      next_state = dec_idle;
          endcase
        end
      end
      dec_sample_nor: begin
        load       = 1'b1;
        next_state = dec_new_make;
      end
      dec_new_make:   next_state = dec_idle;
      dec_wait_rel: begin
        if (rx_byte.valid)
          next_state = (cls == cls_normal) ? dec_sample_rel : dec_idle;
      end
      dec_sample_rel: begin
        load       = 1'b1;
        next_state = dec_new_break;
      end
      dec_new_break:  next_state = dec_idle;
      dec_wait_ext: begin
        if (rx_byte.valid) begin
          if (cls == cls_normal)
            next_state = dec_sample_ext;
          else if (cls == cls_release)
            next_state = dec_wait_ext_rel;
          else
            next_state = dec_idle;   // broken sequence, no event
        end
      end
      dec_sample_ext: begin
        load       = 1'b1;
        ext_bit    = 1'b1;
        next_state = dec_new_make;
      end
      dec_wait_ext_rel: begin
        if (rx_byte.valid)
          next_state = (cls == cls_normal) ? dec_sample_ext_rel : dec_idle;
      end
      dec_sample_ext_rel: begin
        load       = 1'b1;
        ext_bit    = 1'b1;
        next_state = dec_new_break;
      end
      default: next_state = dec_idle;  // recover from illegal encodings
    endcase
  end

  assign key_evt.valid = (state == dec_new_make) || (state == dec_new_break);
  assign key_evt.brk   = (state == dec_new_break);
  assign key_evt.code  = code_q;

  a_evt_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
    key_evt.valid |=> !key_evt.valid);
  a_state_legal: assert property (@(posedge clk) disable iff (!resetN)
    state inside {[dec_idle:dec_sample_ext_rel]});

endmodule

/* test/ps2_clk_gen.sv */
/* testbench clock and reset, 20 ns period
   resetN released on a falling edge after RESET_CYCLES rising edges */
`timescale 1ns/1ps

module ps2_clk_gen #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic resetN
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 50 MHz
  end

  initial begin
    resetN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    resetN = 1'b1;
  end

endmodule

/* test/ps2_kbd_checker.sv */
/* watches the ps2 wires and the apb event reads
   expected events model a fifo of PS2_FIFO_DEPTH that drops pushes when full */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module ps2_kbd_checker (
  input  logic                   clk,
  input  logic                   resetN,
  input  logic                   ps2_clk,
  input  logic                   ps2_data,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`PS2_APB_AW-1:0] paddr,
  input  logic [31:0]            prdata,
  output int                     err_cnt,
  output int                     cmp_cnt
);
  import ps2_kbd_pkg::*;

  key_event_t  exp_q[$];        // events still to be read by software
  logic [10:0] frame_sh = '1;   // [0] start ... [10] stop once full
  int          nbits = 0;
  int          seq_st = 0;      // 0 idle, 1 after F0, 2 after E0, 3 after E0 F0
  int          nxt_st;
  int          errs = 0;
  int          cmps = 0;
  key_event_t  ref_evt;
  key_event_t  exp_evt;

  assign err_cnt = errs;
  assign cmp_cnt = cmps;

  // scan set 2 rules for one byte, unknown bytes abort a sequence
  function automatic void ref_decode(input int st, input logic [7:0] b,
                                     output int st_nxt, output key_event_t evt);
    logic normal;
    normal = (b >= 8'h01) && (b <= 8'h83);
    st_nxt = 0;
    evt    = '0;
    case (st)
      0: begin
        if (normal)
          evt = '{valid: 1'b1, brk: 1'b0, code: {1'b0, b}};
        else if (b == 8'hf0)
          st_nxt = 1;
        else if (b == 8'he0)
          st_nxt = 2;
      end
      1: if (normal) evt = '{valid: 1'b1, brk: 1'b1, code: {1'b0, b}};
      2: begin
        if (normal)
          evt = '{valid: 1'b1, brk: 1'b0, code: {1'b1, b}};
        else if (b == 8'hf0)
          st_nxt = 3;       // E0 F0 prefix
      end
      3: if (normal) evt = '{valid: 1'b1, brk: 1'b1, code: {1'b1, b}};
      default: st_nxt = 0;
    endcase
  endfunction

  // frame capture, data is stable at every ps2 clock fall
  always @(negedge ps2_clk) begin
    frame_sh = {ps2_data, frame_sh[10:1]};
    nbits++;
    if (nbits == 11) begin
      nbits = 0;
      // start low, stop high, odd parity over data and parity bit
      if (!frame_sh[0] && frame_sh[10] && (^frame_sh[9:1])) begin
        ref_decode(seq_st, frame_sh[8:1], nxt_st, ref_evt);
        seq_st = nxt_st;
        if (ref_evt.valid && exp_q.size() < `PS2_FIFO_DEPTH)
          exp_q.push_back(ref_evt);   // a full fifo loses the event
      end
    end
  end

  // compare each valid event read in the access phase
  always @(posedge clk) begin
    if (resetN && psel && penable && !pwrite && paddr == `PS2_REG_EVENT
        && prdata[$bits(key_event_t)-1]) begin
      if (exp_q.size() == 0) begin
        errs++;
        $display("[ERROR] %0t ns: unexpected event %h read", $time, prdata);
      end else begin
        exp_evt = exp_q.pop_front();
        cmps++;
        if (prdata !== 32'(exp_evt)) begin
          errs++;
          $display("[ERROR] %0t ns: event expected %h got %h",
                   $time, 32'(exp_evt), prdata);
        end
      end
    end
  end

endmodule

/* test/ps2_kbd_tb.sv */
/* system-level test of the ps2 keyboard receiver over apb
   ps2 frames use a half period of 10 system cycles, stimulus changes on falling clk */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module ps2_kbd_tb;
  import ps2_kbd_pkg::*;

  localparam int HALF        = 10;                  // ps2 half period in clk cycles
  localparam int NUM_FRAMES  = 29;                  // frames sent by the whole sequence
  localparam int MARGIN      = 10000;               // apb polling and gaps
  localparam int WATCHDOG    = NUM_FRAMES * 11 * 20 + MARGIN;
  localparam int POLL_LIMIT  = 100;                 // status reads before giving up
  localparam int VALID_BIT   = $bits(key_event_t) - 1;
  localparam logic [31:0] CNT_MASK = 32'h0000_000f;
  localparam logic [31:0] PAR_BIT  = 32'h0000_0100;
  localparam logic [31:0] OVF_BIT  = 32'h0000_0200;

  logic                   clk;
  logic                   resetN;
  logic                   ps2_clk;
  logic                   ps2_data;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`PS2_APB_AW-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  int                     chk_errors;
  int                     chk_compares;
  int                     errors = 0;
  int                     checks = 0;
  int                     tests_run = 0;
  int                     tests_ok = 0;
  int                     err_mark = 0;     // error total at the start of a test
  logic [7:0]             code;
  logic [31:0]            st;
  logic [31:0]            rd;

  ps2_clk_gen #(.RESET_CYCLES(10)) ps2_clk_gen_i (.clk(clk), .resetN(resetN));

  ps2_kbd_top ps2_kbd_top_i (
    .clk(clk), .resetN(resetN), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  ps2_kbd_checker ps2_kbd_checker_i (
    .clk(clk), .resetN(resetN), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .prdata(prdata), .err_cnt(chk_errors), .cmp_cnt(chk_compares)
  );

  // one device-to-host frame, parity optionally inverted
  task automatic send_byte(input logic [7:0] b, input bit bad_parity);
    logic [10:0] frame;
    logic        par;
    int          i;
    par   = (~^b) ^ bad_parity;        // odd parity
    frame = {1'b1, par, b, 1'b0};      // stop, parity, data, start
    @(negedge clk);
    for (i = 0; i < 11; i++) begin
      ps2_data = frame[i];             // data moves while ps2_clk is high
      repeat (HALF) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (HALF) @(negedge clk);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (2 * HALF) @(negedge clk);  // idle gap between frames
  endtask

  // access phase response, only status, event and ctrl offsets exist
  task automatic check_response(input logic [`PS2_APB_AW-1:0] addr);
    logic exp_err;
    case (addr)
      `PS2_REG_STATUS, `PS2_REG_EVENT, `PS2_REG_CTRL: exp_err = 1'b0;
      default: exp_err = 1'b1;
    endcase
    check_value("pready", 32'(pready), 32'd1);
    check_value("pslverr", 32'(pslverr), 32'(exp_err));
  endtask

  task automatic apb_read(input logic [`PS2_APB_AW-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;                     // before the pop lands
    check_response(addr);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [`PS2_APB_AW-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    check_response(addr);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  // read status until one of the mask bits is set
  task automatic poll_status(input logic [31:0] mask, output logic [31:0] status);
    int n;
    n = 0;
    apb_read(`PS2_REG_STATUS, status);
    while ((status & mask) == 0 && n < POLL_LIMIT) begin
      apb_read(`PS2_REG_STATUS, status);
      n++;
    end
    if ((status & mask) == 0) begin
      errors++;
      $display("timed out waiting for status bits %h, last status %h", mask, status);
    end
  endtask

  // wait for an event and pop it, the checker judges its value
  task automatic read_event();
    logic [31:0] status;
    logic [31:0] data;
    poll_status(CNT_MASK, status);
    apb_read(`PS2_REG_EVENT, data);
    check_value("event valid bit", 32'(data[VALID_BIT]), 32'd1);
  endtask

  task automatic check_count(input int n);
    logic [31:0] status;
    apb_read(`PS2_REG_STATUS, status);
    check_value("status count", status & CNT_MASK, 32'(n));
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors + chk_errors == err_mark) begin
      tests_ok++;
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      $display("test %0d %s: failed", tests_run, name);
    end
    err_mark = errors + chk_errors;
  endtask

  function automatic logic [7:0] rand_code();
    return 8'($urandom_range(131, 1));   // normal scan code range
  endfunction

  initial begin : stimulus
    void'($urandom(32'h2037));
    ps2_clk  = 1'b1;                     // idle bus is high
    ps2_data = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    @(posedge resetN);
    @(negedge clk);

    repeat (4) begin
      send_byte(rand_code(), 1'b0);
      read_event();
    end
    check_count(0);
    end_test("normal make");

    code = rand_code();
    send_byte(8'hf0, 1'b0);
    send_byte(code, 1'b0);
    read_event();
    send_byte(8'hf0, 1'b0);
    send_byte(8'haa, 1'b0);             // not a key, sequence dropped
    send_byte(rand_code(), 1'b0);       // marker make shows nothing came before it
    read_event();
    check_count(0);
    end_test("break");

    send_byte(8'he0, 1'b0);
    send_byte(rand_code(), 1'b0);
    read_event();
    send_byte(8'he0, 1'b0);
    send_byte(8'hf0, 1'b0);
    send_byte(rand_code(), 1'b0);
    read_event();
    send_byte(8'he0, 1'b0);
    send_byte(8'h84, 1'b0);             // first code above the normal range
    send_byte(rand_code(), 1'b0);
    read_event();
    check_count(0);
    end_test("extended");

    send_byte(rand_code(), 1'b1);
    poll_status(PAR_BIT, st);
    check_value("count after parity error", st & CNT_MASK, 32'd0);
    apb_write(`PS2_REG_CTRL, PAR_BIT);
    apb_read(`PS2_REG_STATUS, st);
    check_value("parity flag after clear", st & PAR_BIT, 32'd0);
    end_test("parity error");

    repeat (`PS2_FIFO_DEPTH + 3) send_byte(rand_code(), 1'b0);
    poll_status(OVF_BIT, st);
    check_value("count when full", st & CNT_MASK, 32'(`PS2_FIFO_DEPTH));
    repeat (`PS2_FIFO_DEPTH) read_event();
    check_count(0);
    apb_write(`PS2_REG_CTRL, OVF_BIT);
    apb_read(`PS2_REG_STATUS, st);
    check_value("overflow flag after clear", st & OVF_BIT, 32'd0);
    end_test("overflow");

    apb_read(`PS2_REG_EVENT, rd);
    check_value("empty event read", rd, 32'd0);
    check_count(0);
    end_test("empty read");

    apb_read('hc, rd);                  // no register here, slave error expected
    check_count(0);
    end_test("unmapped offset");

    $display("tests %0d, passed %0d, checks %0d, events compared %0d, errors %0d",
             tests_run, tests_ok, checks, chk_compares, errors + chk_errors);
    if (errors + chk_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // bounds the run by the frame count of the whole sequence
  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired after %0d clock cycles, the test sequence did not finish",
             WATCHDOG);
    $display("TEST FAILED");
    $finish;
  end

endmodule
